/* cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address width
`define CACHE_ADDR_W 32

// cpu and memory word width
`define CACHE_WORD_W 32

// words in one cache line
`define CACHE_LINE_WORDS 4

// sets per way
`define CACHE_SETS 16

// number of ways
// the single lru bit per set only handles two
`define CACHE_WAYS 2

`endif

/* cache_pkg.sv */
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

   // field widths derived from the geometry
   localparam int LINE_W     = `CACHE_LINE_WORDS * `CACHE_WORD_W;
   localparam int WORD_SEL_W = $clog2(`CACHE_LINE_WORDS);
   localparam int BYTE_SEL_W = $clog2(`CACHE_WORD_W / 8);
   localparam int OFFSET_W   = WORD_SEL_W + BYTE_SEL_W;
   localparam int INDEX_W    = $clog2(`CACHE_SETS);
   localparam int TAG_W      = `CACHE_ADDR_W - INDEX_W - OFFSET_W;

   // request fsm
   typedef enum logic [1:0] {
      idle    = 2'b00,
      lookup  = 2'b01,
      refill  = 2'b10,
      respond = 2'b11
   } ctrl_state_e;

   // byte address as seen by the arrays
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } addr_split_t;

endpackage

`default_nettype wire

/* data_store.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module data_store (
   input  logic                             clk,
   input  logic [cache_pkg::INDEX_W-1:0]    rd_index,
   input  logic [cache_pkg::WORD_SEL_W-1:0] word_sel,
   input  logic                             hit_way,
   fill_if.sink                             fill,
   output logic [`CACHE_WORD_W-1:0]         hit_word
);

   // one line per way per set
   logic [cache_pkg::LINE_W-1:0] line_mem [`CACHE_WAYS][`CACHE_SETS];

   // both ways read every cycle
   logic [cache_pkg::LINE_W-1:0] line_q [`CACHE_WAYS];
   logic [cache_pkg::LINE_W-1:0] sel_line;

   always_ff @(posedge clk) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
         line_q[w] <= line_mem[w][rd_index];
      end

      // finished line from the fill buffer
      if (fill.install) begin
         line_mem[fill.way][fill.index] <= fill.line;
      end
   end

   // way mux then word mux
   assign sel_line = line_q[hit_way];
   assign hit_word = sel_line[word_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

endmodule

`default_nettype wire

/* fill_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface fill_if;

   // from the controller
   logic                          start;
   logic                          uncached;
   logic                          install;
   logic                          way;
   logic [cache_pkg::INDEX_W-1:0] index;

   // from the fill buffer
   logic [cache_pkg::LINE_W-1:0]  line;
   logic                          done;

   modport filler (
      input  start, uncached,
      output line, done
   );

   modport ctrl (
      output start, uncached, install, way, index,
      input  line, done
   );

   modport sink (
      input  install, way, index, line
   );

endinterface

`default_nettype wire

/* icache_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module icache_ctrl (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             ce,
   input  logic                             uncached,
   input  logic [`CACHE_ADDR_W-1:0]         addr,
   input  logic                             rdata_ready,
   input  logic                             hit,
   input  logic                             hit_way,
   input  logic                             victim_way,
   input  logic [`CACHE_WORD_W-1:0]         hit_word,
   fill_if.ctrl                             fill,
   output logic [cache_pkg::INDEX_W-1:0]    rd_index,
   output logic [cache_pkg::TAG_W-1:0]      req_tag,
   output logic [cache_pkg::WORD_SEL_W-1:0] word_sel,
   output logic                             lru_update,
   output logic [`CACHE_WORD_W-1:0]         rdata,
   output logic                             rdata_valid,
   output logic [`CACHE_ADDR_W-1:0]         mem_addr,
   output logic                             mem_ce,
   output mem_bus_pkg::xfer_e               mem_xfer
);

   cache_pkg::ctrl_state_e          state;
   cache_pkg::ctrl_state_e          state_nxt;
   cache_pkg::addr_split_t          addr_in;
   cache_pkg::addr_split_t          req;
   logic                            req_uncached;
   logic                            accept;
   logic                            hit_resp;
   logic                            fill_resp;
   logic                            handshake;
   logic [cache_pkg::WORD_SEL_W-1:0] fill_sel;
   logic [`CACHE_WORD_W-1:0]        fill_word;

   assign addr_in = addr;
   assign accept  = (state == cache_pkg::idle) && ce;

   always_comb begin
      state_nxt = state;
      unique case (state)
         cache_pkg::idle: begin
            if (ce) begin
               state_nxt = cache_pkg::lookup;
            end
         end
         cache_pkg::lookup: begin
            if (req_uncached || !hit) begin
               state_nxt = cache_pkg::refill;
            end else if (rdata_ready) begin
               state_nxt = cache_pkg::idle;
            end
         end
         cache_pkg::refill: begin
            // response already valid in the cycle done rises
            if (fill.done) begin
               state_nxt = rdata_ready ? cache_pkg::idle : cache_pkg::respond;
            end
         end
         cache_pkg::respond: begin
            if (rdata_ready) begin
               state_nxt = cache_pkg::idle;
            end
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state        <= cache_pkg::idle;
         req_uncached <= 1'b0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            req_uncached <= uncached;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req <= addr_in;
      end
   end

   // arrays see the incoming index in idle, the held one after
   assign rd_index = (state == cache_pkg::idle) ? addr_in.index : req.index;
   assign req_tag  = req.tag;
   assign word_sel = req.offset[cache_pkg::OFFSET_W-1:cache_pkg::BYTE_SEL_W];

   // response paths
   assign hit_resp  = (state == cache_pkg::lookup) && !req_uncached && hit;
   assign fill_resp = ((state == cache_pkg::refill) && fill.done) ||
                      (state == cache_pkg::respond);
   assign fill_sel  = req_uncached ? '0 : word_sel;
   assign fill_word = fill.line[fill_sel*`CACHE_WORD_W +: `CACHE_WORD_W];

   assign rdata_valid = hit_resp || fill_resp;
   assign rdata       = fill_resp ? fill_word : hit_word;
   assign handshake   = rdata_valid && rdata_ready;

   // install and lru move only on the handshake
   assign lru_update   = handshake && !req_uncached;
   assign fill.install = handshake && fill_resp && !req_uncached;
   assign fill.way     = fill_resp ? victim_way : hit_way;
   assign fill.index   = req.index;
   assign fill.start   = accept;
   assign fill.uncached = req_uncached;

   // memory request held until the last beat is in
   assign mem_ce   = (state == cache_pkg::refill) && !fill.done;
   assign mem_addr = req_uncached ? req :
                     {req.tag, req.index, {cache_pkg::OFFSET_W{1'b0}}};
   assign mem_xfer = req_uncached ? mem_bus_pkg::xfer_word : mem_bus_pkg::xfer_line;

endmodule

`default_nettype wire

/* icache_props.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module icache_props (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ce,
   input  logic                     uncached,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  logic [`CACHE_WORD_W-1:0] rdata,
   input  logic                     rdata_valid,
   input  logic                     rdata_ready,
   input  logic [`CACHE_ADDR_W-1:0] mem_addr,
   input  logic                     mem_ce,
   input  mem_bus_pkg::xfer_e       mem_xfer,
   input  logic                     mem_rdata_valid
);

   int   fail_count = 0;
   int   beat_cnt;
   logic seen_ce;

   // memory contents as the testbench model defines them
   function automatic logic [`CACHE_WORD_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] a);
      return {a[`CACHE_ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         seen_ce <= 1'b0;
      end else if (ce) begin
         seen_ce <= 1'b1;
      end
   end

   // beats of the current memory request
   always_ff @(posedge clk) begin
      if (reset || !mem_ce) begin
         beat_cnt <= 0;
      end else if (mem_rdata_valid) begin
         beat_cnt <= beat_cnt + 1;
      end
   end

   a_quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
      !seen_ce |-> !rdata_valid && !mem_ce)
   else begin
      $error("Response or memory request seen before the first request");
      fail_count++;
   end

   a_rdata_value: assert property (@(posedge clk) disable iff (reset)
      rdata_valid && rdata_ready |-> rdata == mem_word(addr))
   else begin
      $error("Mismatch at %0t: rdata %h for addr %h", $time, $sampled(rdata), $sampled(addr));
      fail_count++;
   end

   a_rdata_held: assert property (@(posedge clk) disable iff (reset)
      rdata_valid && !rdata_ready |=> rdata_valid && $stable(rdata))
   else begin
      $error("Response dropped or changed while the CPU was not ready");
      fail_count++;
   end

   a_line_request: assert property (@(posedge clk) disable iff (reset)
      mem_ce && !uncached |->
         mem_xfer == mem_bus_pkg::xfer_line &&
         mem_addr == (addr & ~(`CACHE_LINE_WORDS * 4 - 1)))
   else begin
      $error("Mismatch at %0t: line refill request type or address wrong", $time);
      fail_count++;
   end

   a_word_request: assert property (@(posedge clk) disable iff (reset)
      mem_ce && uncached |-> mem_xfer == mem_bus_pkg::xfer_word && mem_addr == addr)
   else begin
      $error("Mismatch at %0t: uncached request type or address wrong", $time);
      fail_count++;
   end

   a_request_stable: assert property (@(posedge clk) disable iff (reset)
      mem_ce |=> !mem_ce || ($stable(mem_addr) && $stable(mem_xfer)))
   else begin
      $error("Memory address or transfer type changed while mem_ce was high");
      fail_count++;
   end

   a_beat_count: assert property (@(posedge clk) disable iff (reset)
      $fell(mem_ce) |-> beat_cnt == (uncached ? 1 : `CACHE_LINE_WORDS))
   else begin
      $error("Memory request ended after the wrong number of beats");
      fail_count++;
   end

endmodule

bind icache_top icache_props props0 (.*);

`default_nettype wire

/* icache_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module icache_tb;

   logic                     clk = 1'b0;
   logic                     reset = 1'b1;
   logic                     ce;
   logic                     uncached;
   logic [`CACHE_ADDR_W-1:0] addr;
   logic [`CACHE_WORD_W-1:0] rdata;
   logic                     rdata_valid;
   logic                     rdata_ready;
   logic [`CACHE_ADDR_W-1:0] mem_addr;
   logic                     mem_ce;
   mem_bus_pkg::xfer_e       mem_xfer;
   logic [`CACHE_WORD_W-1:0] mem_rdata;
   logic                     mem_rdata_valid;

   integer seed = 32'h5360;
   int     tb_errors = 0;
   int     mem_reqs = 0;
   int     line_fills = 0;
   logic   mem_ce_prev = 1'b0;
   int     beat_idx = 0;
   int     beat_total;
   int     gap = -1;

   icache_top dut0 (.*);

   always #20 clk = ~clk;

   function automatic logic [`CACHE_WORD_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] a);
      return {a[`CACHE_ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
   endfunction

   // memory model with 0 to 4 idle cycles before each beat
   always @(negedge clk) begin
      mem_rdata_valid = 1'b0;
      beat_total = (mem_xfer == mem_bus_pkg::xfer_line) ? `CACHE_LINE_WORDS : 1;
      if (!mem_ce) begin
         beat_idx = 0;
         gap = -1;
      end else begin
         if (gap < 0) begin
            gap = {$random(seed)} % 5;
         end
         if (gap > 0) begin
            gap--;
         end else if (beat_idx < beat_total) begin
            mem_rdata = mem_word(mem_addr + 4 * beat_idx);
            mem_rdata_valid = 1'b1;
            beat_idx++;
            gap = {$random(seed)} % 5;
         end
      end
   end

   // count memory requests and line refills
   always @(negedge clk) begin
      if (mem_ce && !mem_ce_prev) begin
         mem_reqs++;
         if (mem_xfer == mem_bus_pkg::xfer_line) begin
            line_fills++;
         end
      end
      mem_ce_prev = mem_ce;
   end

   // one request with random back-pressure
   // exp_mem below zero skips the request count
   task automatic read_word(input logic [`CACHE_ADDR_W-1:0] a, input logic unc,
                            input int exp_mem);
      int stall;
      int reqs_before;
      stall = {$random(seed)} % 5;
      reqs_before = mem_reqs;
      ce = 1'b1;
      addr = a;
      uncached = unc;
      @(negedge clk);
      ce = 1'b0;
      while (!rdata_valid) begin
         @(negedge clk);
      end
      repeat (stall) @(negedge clk);
      rdata_ready = 1'b1;
      @(negedge clk);
      rdata_ready = 1'b0;
      if (exp_mem >= 0 && mem_reqs - reqs_before != exp_mem) begin
         tb_errors++;
         $display("Mismatch at %0t: addr %h made %0d memory requests, expected %0d",
                  $time, a, mem_reqs - reqs_before, exp_mem);
      end
   endtask

   initial begin
      logic [`CACHE_ADDR_W-1:0] rnd_addr;
      logic                     rnd_unc;
      int                       fills_before;
      ce = 1'b0;
      uncached = 1'b0;
      addr = '0;
      rdata_ready = 1'b0;
      mem_rdata = '0;
      mem_rdata_valid = 1'b0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
      repeat (3) @(negedge clk);

      // mixed traffic confined to sets 0 to 7
      for (int i = 0; i < 24; i++) begin
         rnd_addr = {$random(seed)} & 32'h0000_0F7C;
         rnd_unc = ({$random(seed)} % 8) == 0;
         read_word(rnd_addr, rnd_unc, -1);
      end

      // same line of set 8 right after its refill
      read_word(32'h0000_1080, 1'b0, 1);
      read_word(32'h0000_1084, 1'b0, 0);

      // A B A C in set 9
      // then A hits and B was evicted
      fills_before = line_fills;
      read_word(32'h0000_0090, 1'b0, 1);
      read_word(32'h0001_0090, 1'b0, 1);
      read_word(32'h0000_0094, 1'b0, 0);
      read_word(32'h0002_0098, 1'b0, 1);
      read_word(32'h0000_009C, 1'b0, 0);
      read_word(32'h0001_0090, 1'b0, 1);
      if (line_fills - fills_before != 4) begin
         tb_errors++;
         $display("Mismatch at %0t: %0d line refills in set 9, expected 4",
                  $time, line_fills - fills_before);
      end

      // uncached read inside a cached line of set 12
      read_word(32'h0000_20C0, 1'b0, 1);
      read_word(32'h0000_20C8, 1'b1, 1);
      read_word(32'h0000_20C4, 1'b0, 0);

      repeat (2) @(negedge clk);
      $display("Summary: %0d testbench errors, %0d assertion failures",
               tb_errors, dut0.props0.fail_count);
      if (tb_errors == 0 && dut0.props0.fail_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // 40 requests of 12 cycles plus stalls and gaps stay far below this
   initial begin
      repeat (4000) @(posedge clk);
      $display("Timeout: the run did not finish within 4000 cycles");
      $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* icache_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module icache_top (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     ce,
   input  logic                     uncached,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   output logic [`CACHE_WORD_W-1:0] rdata,
   output logic                     rdata_valid,
   input  logic                     rdata_ready,
   output logic [`CACHE_ADDR_W-1:0] mem_addr,
   output logic                     mem_ce,
   output mem_bus_pkg::xfer_e       mem_xfer,
   input  logic [`CACHE_WORD_W-1:0] mem_rdata,
   input  logic                     mem_rdata_valid
);

   logic                             hit;
   logic                             hit_way;
   logic                             victim_way;
   logic [`CACHE_WORD_W-1:0]         hit_word;
   logic [cache_pkg::INDEX_W-1:0]    rd_index;
   logic [cache_pkg::TAG_W-1:0]      req_tag;
   logic [cache_pkg::WORD_SEL_W-1:0] word_sel;
   logic                             lru_update;

   fill_if fill_bus ();

   icache_ctrl u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .ce          (ce),
      .uncached    (uncached),
      .addr        (addr),
      .rdata_ready (rdata_ready),
      .hit         (hit),
      .hit_way     (hit_way),
      .victim_way  (victim_way),
      .hit_word    (hit_word),
      .fill        (fill_bus.ctrl),
      .rd_index    (rd_index),
      .req_tag     (req_tag),
      .word_sel    (word_sel),
      .lru_update  (lru_update),
      .rdata       (rdata),
      .rdata_valid (rdata_valid),
      .mem_addr    (mem_addr),
      .mem_ce      (mem_ce),
      .mem_xfer    (mem_xfer)
   );

   tag_store u_tags (
      .clk        (clk),
      .reset      (reset),
      .rd_index   (rd_index),
      .req_tag    (req_tag),
      .lru_update (lru_update),
      .fill       (fill_bus.sink),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way)
   );

   line_fill_buffer u_lfb (
      .clk             (clk),
      .reset           (reset),
      .mem_rdata       (mem_rdata),
      .mem_rdata_valid (mem_rdata_valid),
      .fill            (fill_bus.filler)
   );

   data_store u_data (
      .clk      (clk),
      .rd_index (rd_index),
      .word_sel (word_sel),
      .hit_way  (hit_way),
      .fill     (fill_bus.sink),
      .hit_word (hit_word)
   );

endmodule

`default_nettype wire

/* line_fill_buffer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module line_fill_buffer (
   input  logic                     clk,
   input  logic                     reset,
   input  logic [`CACHE_WORD_W-1:0] mem_rdata,
   input  logic                     mem_rdata_valid,
   fill_if.filler                   fill
);

   localparam mem_bus_pkg::beat_count_t LAST_BEAT =
      mem_bus_pkg::beat_count_t'(`CACHE_LINE_WORDS - 1);

   mem_bus_pkg::beat_count_t     beat_count;
   logic                         done_q;
   logic [cache_pkg::LINE_W-1:0] line_q;
   logic                         take_beat;

   // beats after done are ignored until the next start
   assign take_beat = mem_rdata_valid && !done_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_count <= '0;
         done_q     <= 1'b0;
      end else if (fill.start) begin
         beat_count <= '0;
         done_q     <= 1'b0;
      end else if (take_beat) begin
         beat_count <= beat_count + 1'b1;
         if (fill.uncached || beat_count == LAST_BEAT) begin
            done_q <= 1'b1;
         end
      end
   end

   // beats enter at the top so the first one ends up in word 0
   always_ff @(posedge clk) begin
      if (take_beat) begin
         if (fill.uncached) begin
            // single word goes straight to word 0
            line_q <= {{(cache_pkg::LINE_W - `CACHE_WORD_W){1'b0}}, mem_rdata};
         end else begin
            line_q <= {mem_rdata, line_q[cache_pkg::LINE_W-1:`CACHE_WORD_W]};
         end
      end
   end

   assign fill.line = line_q;
   assign fill.done = done_q;

endmodule

`default_nettype wire

/* mem_bus_pkg.sv */
`default_nettype none
`include "cache_defs.svh"

package mem_bus_pkg;

   // transfer type on the memory side
   typedef enum logic [2:0] {
      xfer_word = 3'b001,
      xfer_line = 3'b100
   } xfer_e;

   // counts beats up to a full line
   typedef logic [$clog2(`CACHE_LINE_WORDS + 1)-1:0] beat_count_t;

endpackage

`default_nettype wire

/* sources.f */
+incdir+.
cache_pkg.sv
mem_bus_pkg.sv
fill_if.sv
tag_store.sv
line_fill_buffer.sv
data_store.sv
icache_ctrl.sv
icache_top.sv
icache_props.sv
icache_tb.sv

/* tag_store.sv */
`timescale 1ns/100ps
`default_nettype none
`include "cache_defs.svh"

module tag_store (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [cache_pkg::INDEX_W-1:0] rd_index,
   input  logic [cache_pkg::TAG_W-1:0]   req_tag,
   input  logic                          lru_update,
   fill_if.sink                          fill,
   output logic                          hit,
   output logic                          hit_way,
   output logic                          victim_way
);

   logic [cache_pkg::TAG_W-1:0] tag_mem [`CACHE_WAYS][`CACHE_SETS];
   logic [`CACHE_SETS-1:0]      valid_mem [`CACHE_WAYS];
   logic [`CACHE_SETS-1:0]      lru_mem;

   // registered read port
   logic [cache_pkg::TAG_W-1:0] tag_q [`CACHE_WAYS];
   logic [`CACHE_WAYS-1:0]      valid_q;
   logic                        lru_q;

   logic [`CACHE_WAYS-1:0]      way_hit;

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int w = 0; w < `CACHE_WAYS; w++) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
               tag_mem[w][s] <= '0;
            end
            valid_mem[w] <= '0;
            tag_q[w]     <= '0;
         end
         lru_mem <= '0;
         valid_q <= '0;
         lru_q   <= 1'b0;
      end else begin
         for (int w = 0; w < `CACHE_WAYS; w++) begin
            tag_q[w]   <= tag_mem[w][rd_index];
            valid_q[w] <= valid_mem[w][rd_index];
         end
         lru_q <= lru_mem[rd_index];

         // refill writes tag and valid into the victim way
         if (fill.install) begin
            tag_mem[fill.way][fill.index]   <= req_tag;
            valid_mem[fill.way][fill.index] <= 1'b1;
         end

         // lru points at the way not just used
         if (fill.install || lru_update) begin
            lru_mem[fill.index] <= ~fill.way;
         end
      end
   end

   // compare both ways
   always_comb begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
         way_hit[w] = valid_q[w] && (tag_q[w] == req_tag);
      end
   end

   assign hit        = |way_hit;
   assign hit_way    = way_hit[1];
   assign victim_way = lru_q;

endmodule

`default_nettype wire
